// ==== logic/rv_pkg.sv ====
package rv_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [31:0] inst_word_t;
	typedef logic [3:0] byte_strb_t;   // bit 3 is lane 0 in bits 31:24

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	localparam xlen_t PC_STEP  = 32'd4;
	localparam xlen_t RESET_PC = 32'd0;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL,
		ALU_SRL, ALU_SRA, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} alu_op_t;

	typedef enum logic [1:0] {
		MEM_BYTE,
		MEM_HALF,
		MEM_WORD
	} mem_size_t;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_DECODE,
		ST_EXEC,
		ST_MEM,
		ST_WRITE
	} core_state_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic use_imm;       // second alu operand from imm
		logic is_lui;
		logic is_auipc;
		logic is_jal;
		logic is_jalr;
		logic is_branch;
		logic is_load;
		logic is_store;
		mem_size_t mem_size;
		logic load_unsigned;
		logic rd_write;
		logic valid;
	} dec_t;

	typedef struct packed {
		xlen_t addr;
		logic valid;
	} bus_rd_req_t;

	typedef struct packed {
		xlen_t addr;
		xlen_t data;
		byte_strb_t strb;
		logic aw_valid;
		logic w_valid;
	} bus_wr_req_t;

endpackage

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
	input logic clk,
	input logic rstn,
	input rv_pkg::inst_word_t inst,
	output rv_pkg::dec_t dec,
	output rv_pkg::reg_idx_t rd,
	output rv_pkg::reg_idx_t rs1,
	output rv_pkg::reg_idx_t rs2,
	output rv_pkg::xlen_t imm
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic fmt_r;
	logic fmt_i;
	logic fmt_s;
	logic fmt_b;
	logic fmt_u;
	logic fmt_j;
	alu_op_t ari_op;   // shared by op and op-imm
	dec_t d;
	xlen_t imm_c;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign fmt_r = opcode == OPC_OP;
	assign fmt_i = opcode == OPC_OP_IMM || opcode == OPC_LOAD || opcode == OPC_JALR;
	assign fmt_s = opcode == OPC_STORE;
	assign fmt_b = opcode == OPC_BRANCH;
	assign fmt_u = opcode == OPC_LUI || opcode == OPC_AUIPC;
	assign fmt_j = opcode == OPC_JAL;

	// indices go straight to the register file read ports
	assign rs1 = (fmt_r | fmt_i | fmt_s | fmt_b) ? inst[19:15] : '0;
	assign rs2 = (fmt_r | fmt_s | fmt_b) ? inst[24:20] : '0;

	assign imm_c = fmt_i ? {{20{inst[31]}}, inst[31:20]} :
		fmt_s ? {{20{inst[31]}}, inst[31:25], inst[11:7]} :
		fmt_b ? {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0} :
		fmt_u ? {inst[31:12], 12'd0} :
		fmt_j ? {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0} : '0;

	always_comb begin
		case (funct3)
			3'b000: ari_op = (fmt_r && funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001: ari_op = ALU_SLL;
			3'b010: ari_op = ALU_SLT;
			3'b011: ari_op = ALU_SLTU;
			3'b100: ari_op = ALU_XOR;
			3'b101: ari_op = funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110: ari_op = ALU_OR;
			default: ari_op = ALU_AND;
		endcase
	end

	always_comb begin
		d = '0;
		d.load_unsigned = funct3[2];
		d.mem_size = (funct3[1:0] == 2'b00) ? MEM_BYTE :
			(funct3[1:0] == 2'b01) ? MEM_HALF : MEM_WORD;
		d.use_imm = fmt_i;
		d.rd_write = fmt_r | fmt_i | fmt_u | fmt_j;
		d.alu_op = (fmt_r || opcode == OPC_OP_IMM) ? ari_op : ALU_ADD;
		d.is_lui = opcode == OPC_LUI;
		d.is_auipc = opcode == OPC_AUIPC;
		d.is_jal = fmt_j;
		d.is_jalr = opcode == OPC_JALR;
		d.is_branch = fmt_b;
		d.is_load = opcode == OPC_LOAD;
		d.is_store = fmt_s;
		case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL: d.valid = 1'b1;
			OPC_JALR: d.valid = funct3 == 3'b000;
			OPC_LOAD: d.valid = funct3 != 3'b011 && funct3[2:1] != 2'b11;
			OPC_STORE: d.valid = !funct3[2] && funct3[1:0] != 2'b11;
			OPC_BRANCH: begin
				d.valid = funct3[2:1] != 2'b01;
				case (funct3)
					3'b000: d.alu_op = ALU_EQ;
					3'b001: d.alu_op = ALU_NE;
					3'b100: d.alu_op = ALU_LT;
					3'b101: d.alu_op = ALU_GE;
					3'b110: d.alu_op = ALU_LTU;
					default: d.alu_op = ALU_GEU;
				endcase
			end
			OPC_OP_IMM: d.valid = (funct3 == 3'b001) ? funct7 == 7'b0000000 :
				(funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) : 1'b1;
			OPC_OP: d.valid = funct7 == 7'b0000000 ||
				(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
			default: d.valid = 1'b0;
		endcase
		if (!d.valid)
			d = '0;   // unknown word retires as a nop
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			dec <= '0;
			rd <= '0;
		end else begin
			dec <= d;
			rd <= inst[11:7];
		end
		imm <= imm_c;
	end

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
	input logic clk,
	input logic rstn,
	input rv_pkg::reg_idx_t rd,
	input logic rd_en,
	input rv_pkg::xlen_t rd_data,
	input rv_pkg::reg_idx_t rs1,
	input rv_pkg::reg_idx_t rs2,
	output rv_pkg::xlen_t rs1_val,
	output rv_pkg::xlen_t rs2_val
);
	import rv_pkg::*;

	xlen_t regs [1:31];   // x0 has no storage

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_en && rd != '0) begin
			regs[rd] <= rd_data;
		end
	end

	always_ff @(posedge clk) begin
		rs1_val <= (rs1 == '0) ? '0 : regs[rs1];
		rs2_val <= (rs2 == '0) ? '0 : regs[rs2];
	end

endmodule

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
	input logic clk,
	input logic rstn,
	input rv_pkg::alu_op_t op,
	input rv_pkg::xlen_t src1,
	input rv_pkg::xlen_t src2,
	output rv_pkg::xlen_t result
);
	import rv_pkg::*;

	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;
	logic eq;

	assign shamt = src2[4:0];
	assign lt_s = $signed(src1) < $signed(src2);
	assign lt_u = src1 < src2;
	assign eq = src1 == src2;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			result <= '0;
		end else begin
			case (op)
				ALU_ADD: result <= src1 + src2;
				ALU_SUB: result <= src1 - src2;
				ALU_SLT, ALU_LT: result <= {31'd0, lt_s};
				ALU_SLTU, ALU_LTU: result <= {31'd0, lt_u};
				ALU_XOR: result <= src1 ^ src2;
				ALU_OR: result <= src1 | src2;
				ALU_AND: result <= src1 & src2;
				ALU_SLL: result <= src1 << shamt;
				ALU_SRL: result <= src1 >> shamt;
				ALU_SRA: result <= $signed(src1) >>> shamt;
				ALU_EQ: result <= {31'd0, eq};
				ALU_NE: result <= {31'd0, !eq};
				ALU_GE: result <= {31'd0, !lt_s};
				ALU_GEU: result <= {31'd0, !lt_u};
			endcase
		end
	end

endmodule

// ==== logic/rv_mem_align.sv ====
`timescale 1ns/1ps

module rv_mem_align (
	input rv_pkg::mem_size_t size,
	input logic load_unsigned,
	input logic [1:0] addr_lo,
	input rv_pkg::xlen_t store_val,
	input rv_pkg::xlen_t rdata,
	output rv_pkg::xlen_t wdata,
	output rv_pkg::byte_strb_t strb,
	output rv_pkg::xlen_t load_val
);
	import rv_pkg::*;

	xlen_t lane_b;          // addressed byte moved up to 31:24
	logic [15:0] lane_h;
	logic sext_b;
	logic sext_h;

	assign lane_b = rdata << {addr_lo, 3'b000};
	assign lane_h = addr_lo[1] ? rdata[15:0] : rdata[31:16];   // bit 0 ignored
	assign sext_b = !load_unsigned && lane_b[31];
	assign sext_h = !load_unsigned && lane_h[15];

	always_comb begin
		case (size)
			MEM_BYTE: begin
				wdata = {store_val[7:0], 24'd0} >> {addr_lo, 3'b000};
				strb = 4'b1000 >> addr_lo;
				load_val = {{24{sext_b}}, lane_b[31:24]};
			end
			MEM_HALF: begin
				wdata = addr_lo[1] ? {16'd0, store_val[15:0]} : {store_val[15:0], 16'd0};
				strb = addr_lo[1] ? 4'b0011 : 4'b1100;
				load_val = {{16{sext_h}}, lane_h};
			end
			default: begin
				wdata = store_val;
				strb = 4'b1111;
				load_val = rdata;
			end
		endcase
	end

endmodule

// ==== logic/rv_bus_master.sv ====
`timescale 1ns/1ps

module rv_bus_master (
	input logic clk,
	input logic rstn,
	input logic start_rd,
	input logic start_wr,
	input rv_pkg::xlen_t addr,
	input rv_pkg::xlen_t wdata,
	input rv_pkg::byte_strb_t wstrb,
	output rv_pkg::bus_rd_req_t rd_req,
	output logic r_ready,
	input logic ar_ready,
	input logic r_valid,
	input rv_pkg::xlen_t r_data,
	output rv_pkg::bus_wr_req_t wr_req,
	input logic aw_ready,
	input logic w_ready,
	input logic b_valid,
	output logic b_ready,
	output logic done,
	output rv_pkg::xlen_t rdata
);
	import rv_pkg::*;

	typedef enum logic [2:0] {
		BM_IDLE,
		BM_AR,
		BM_R,
		BM_W,
		BM_B
	} bm_state_t;

	bm_state_t state;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= BM_IDLE;
			rd_req.valid <= 1'b0;
			r_ready <= 1'b0;
			wr_req.aw_valid <= 1'b0;
			wr_req.w_valid <= 1'b0;
			wr_req.strb <= '0;
			b_ready <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				BM_IDLE: begin
					if (start_rd) begin
						rd_req.addr <= {addr[31:2], 2'b00};
						rd_req.valid <= 1'b1;
						state <= BM_AR;
					end else if (start_wr) begin
						wr_req.addr <= {addr[31:2], 2'b00};
						wr_req.data <= wdata;
						wr_req.strb <= wstrb;
						wr_req.aw_valid <= 1'b1;
						wr_req.w_valid <= 1'b1;
						state <= BM_W;
					end
				end
				BM_AR: begin
					if (ar_ready) begin
						rd_req.valid <= 1'b0;
						r_ready <= 1'b1;
						state <= BM_R;
					end
				end
				BM_R: begin
					if (r_valid) begin
						r_ready <= 1'b0;
						rdata <= r_data;
						done <= 1'b1;
						state <= BM_IDLE;
					end
				end
				BM_W: begin
					if (aw_ready)
						wr_req.aw_valid <= 1'b0;
					if (w_ready)
						wr_req.w_valid <= 1'b0;
					if (!wr_req.aw_valid && !wr_req.w_valid) begin   // both sides taken
						b_ready <= 1'b1;
						state <= BM_B;
					end
				end
				BM_B: begin
					if (b_valid) begin
						b_ready <= 1'b0;
						done <= 1'b1;
						state <= BM_IDLE;
					end
				end
				default: state <= BM_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
	input logic clk,
	input logic rstn,
	output rv_pkg::bus_rd_req_t rd_req,
	output logic r_ready,
	input logic ar_ready,
	input rv_pkg::xlen_t r_data,
	input logic r_valid,
	output rv_pkg::bus_wr_req_t wr_req,
	output logic b_ready,
	input logic aw_ready,
	input logic w_ready,
	input logic b_valid
);
	import rv_pkg::*;

	core_state_t state;
	xlen_t pc;
	inst_word_t instr;   // held for the decoder until write
	logic busy;          // bus request already issued

	dec_t dec;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	xlen_t imm;
	xlen_t rs1_val;
	xlen_t rs2_val;
	xlen_t alu_src2;
	xlen_t alu_result;
	xlen_t ea;
	xlen_t st_data;
	byte_strb_t st_strb;
	xlen_t ld_val;
	xlen_t bus_addr;
	xlen_t bus_rdata;
	logic bus_done;
	logic start_rd;
	logic start_wr;
	logic is_mem;
	logic rd_en;
	xlen_t wb_val;
	xlen_t next_pc;

	assign ea = rs1_val + imm;
	assign alu_src2 = dec.use_imm ? imm : rs2_val;
	assign is_mem = dec.is_load | dec.is_store;
	assign start_rd = !busy && (state == ST_FETCH || (state == ST_MEM && dec.is_load));
	assign start_wr = !busy && state == ST_MEM && dec.is_store;
	assign bus_addr = (state == ST_FETCH) ? pc : ea;
	assign rd_en = state == ST_WRITE && dec.rd_write;

	assign wb_val = dec.is_lui ? imm :
		dec.is_auipc ? pc + imm :
		(dec.is_jal | dec.is_jalr) ? pc + PC_STEP :
		dec.is_load ? ld_val : alu_result;

	always_comb begin
		if (dec.is_jal || (dec.is_branch && alu_result != '0))
			next_pc = pc + imm;
		else if (dec.is_jalr)
			next_pc = {ea[31:1], 1'b0};
		else
			next_pc = pc + PC_STEP;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ST_FETCH;
			pc <= RESET_PC;
			busy <= 1'b0;
		end else begin
			case (state)
				ST_FETCH: begin
					if (start_rd)
						busy <= 1'b1;
					if (bus_done) begin
						busy <= 1'b0;
						instr <= bus_rdata;
						state <= ST_DECODE;
					end
				end
				ST_DECODE: state <= ST_EXEC;
				ST_EXEC: state <= ST_MEM;
				ST_MEM: begin
					if (start_rd || start_wr)
						busy <= 1'b1;
					if (!is_mem || bus_done) begin
						busy <= 1'b0;
						state <= ST_WRITE;
					end
				end
				ST_WRITE: begin
					pc <= next_pc;
					state <= ST_FETCH;
				end
				default: state <= ST_FETCH;
			endcase
		end
	end

	rv_decoder u_decoder (
		.clk(clk), .rstn(rstn), .inst(instr), .dec(dec),
		.rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm)
	);

	rv_regfile u_regfile (
		.clk(clk), .rstn(rstn), .rd(rd), .rd_en(rd_en), .rd_data(wb_val),
		.rs1(rs1), .rs2(rs2), .rs1_val(rs1_val), .rs2_val(rs2_val)
	);

	rv_alu u_alu (
		.clk(clk), .rstn(rstn), .op(dec.alu_op),
		.src1(rs1_val), .src2(alu_src2), .result(alu_result)
	);

	rv_mem_align u_mem_align (
		.size(dec.mem_size), .load_unsigned(dec.load_unsigned), .addr_lo(ea[1:0]),
		.store_val(rs2_val), .rdata(bus_rdata),
		.wdata(st_data), .strb(st_strb), .load_val(ld_val)
	);

	rv_bus_master u_bus_master (
		.clk(clk), .rstn(rstn), .start_rd(start_rd), .start_wr(start_wr),
		.addr(bus_addr), .wdata(st_data), .wstrb(st_strb),
		.rd_req(rd_req), .r_ready(r_ready), .ar_ready(ar_ready),
		.r_valid(r_valid), .r_data(r_data),
		.wr_req(wr_req), .aw_ready(aw_ready), .w_ready(w_ready),
		.b_valid(b_valid), .b_ready(b_ready),
		.done(bus_done), .rdata(bus_rdata)
	);

endmodule

// ==== include/rv_iss_model.svh ====
`ifndef RV_ISS_MODEL_SVH
`define RV_ISS_MODEL_SVH

import rv_pkg::*;

localparam int ISS_MEM_WORDS = 1024;   // 4 KiB image

xlen_t iss_mem [ISS_MEM_WORDS];
xlen_t iss_x [32];
xlen_t iss_pc;
int unsigned iss_writes;
xlen_t iss_waddr;      // last store as the bus carries it
xlen_t iss_wdata;
byte_strb_t iss_wstrb;

function automatic void reset_model();
	iss_x = '{default: '0};
	iss_pc = RESET_PC;
	iss_writes = 0;
endfunction

function automatic xlen_t alu_value(input logic [2:0] f3, input logic alt, input xlen_t a,
		input xlen_t b);
	case (f3)
		3'b000: return alt ? a - b : a + b;
		3'b001: return a << b[4:0];
		3'b010: return {31'd0, $signed(a) < $signed(b)};
		3'b011: return {31'd0, a < b};
		3'b100: return a ^ b;
		3'b101: begin
			if (alt)
				return $signed(a) >>> b[4:0];
			return a >> b[4:0];
		end
		3'b110: return a | b;
		default: return a & b;
	endcase
endfunction

function automatic bit branch_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
	case (f3)
		3'b000: return a == b;
		3'b001: return a != b;
		3'b100: return $signed(a) < $signed(b);
		3'b101: return $signed(a) >= $signed(b);
		3'b110: return a < b;
		default: return a >= b;
	endcase
endfunction

function automatic void step_model();
	inst_word_t w;
	logic [2:0] f3;
	xlen_t a;
	xlen_t b;
	xlen_t imm_i;
	xlen_t ea;
	xlen_t nxt;
	xlen_t wb;
	xlen_t word;
	logic wr;
	int nbytes;
	int first;
	int lane;

	w = iss_mem[iss_pc[11:2]];
	f3 = w[14:12];
	a = iss_x[w[19:15]];
	b = iss_x[w[24:20]];
	imm_i = {{20{w[31]}}, w[31:20]};
	ea = a + ((w[6:0] == OPC_STORE) ? {{20{w[31]}}, w[31:25], w[11:7]} : imm_i);
	nbytes = 1 << f3[1:0];
	first = int'(ea[1:0]) & ~(nbytes - 1);   // offset of the first byte touched
	nxt = iss_pc + PC_STEP;
	wb = nxt;   // link value for jal and jalr
	wr = 1'b1;
	case (w[6:0])
		OPC_LUI: wb = {w[31:12], 12'd0};
		OPC_AUIPC: wb = iss_pc + {w[31:12], 12'd0};
		OPC_JAL: nxt = iss_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		OPC_JALR: nxt = {ea[31:1], 1'b0};
		OPC_BRANCH: begin
			wr = 1'b0;
			if (branch_taken(f3, a, b))
				nxt = iss_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		end
		OPC_LOAD: begin
			word = iss_mem[ea[11:2]];
			wb = '0;
			for (int j = 0; j < nbytes; j++)
				wb = {wb[23:0], word[8 * (3 - first - j) +: 8]};
			if (!f3[2] && nbytes < 4 && wb[8 * nbytes - 1])
				wb = wb | (32'hffff_ffff << (8 * nbytes));   // sign extension
		end
		OPC_STORE: begin
			wr = 1'b0;
			word = iss_mem[ea[11:2]];
			iss_waddr = {ea[31:2], 2'b00};
			iss_wstrb = '0;
			iss_wdata = '0;
			for (int j = 0; j < nbytes; j++) begin
				lane = 3 - first - j;   // byte offset n is lane 3-n
				iss_wstrb[lane] = 1'b1;
				iss_wdata[8 * lane +: 8] = b[8 * (nbytes - 1 - j) +: 8];
				word[8 * lane +: 8] = iss_wdata[8 * lane +: 8];
			end
			iss_mem[ea[11:2]] = word;
			iss_writes++;
		end
		OPC_OP_IMM: wb = alu_value(f3, f3 == 3'b101 && w[30], a, imm_i);
		OPC_OP: wb = alu_value(f3, w[30], a, b);
		default: wr = 1'b0;
	endcase
	if (wr && w[11:7] != '0)
		iss_x[w[11:7]] = wb;
	iss_pc = nxt;
endfunction

`endif

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;
	`include "rv_iss_model.svh"

	localparam int RUN_LIMIT = 100000;   // cycles for the whole program
	localparam int HS_LIMIT = 100;       // cycles one handshake may stall
	localparam logic [11:0] DATA_BASE = 12'h700;

	logic clk = 1'b0;
	logic rstn = 1'b0;
	bus_rd_req_t rd_req;
	logic r_ready;
	logic ar_ready = 1'b0;
	xlen_t r_data = '0;
	logic r_valid = 1'b0;
	bus_wr_req_t wr_req;
	logic b_ready;
	logic aw_ready = 1'b0;
	logic w_ready = 1'b0;
	logic b_valid = 1'b0;

	integer seed = 32'hb02263ae;
	xlen_t mem [ISS_MEM_WORDS];   // memory behind the bus
	int prog_len;
	xlen_t end_pc;
	xlen_t rd_addr;
	logic rd_pend = 1'b0;
	logic aw_seen = 1'b0;
	logic w_seen = 1'b0;
	logic load_pending = 1'b0;
	xlen_t load_addr;
	int unsigned ar_count = 0;
	int unsigned r_count = 0;
	int unsigned aw_count = 0;
	int unsigned b_count = 0;
	int end_hits = 0;
	int stall = 0;

	always #4 clk = ~clk;

	rv_core rv_core_inst (
		.clk(clk), .rstn(rstn), .rd_req(rd_req), .r_ready(r_ready), .ar_ready(ar_ready),
		.r_data(r_data), .r_valid(r_valid), .wr_req(wr_req), .b_ready(b_ready),
		.aw_ready(aw_ready), .w_ready(w_ready), .b_valid(b_valid)
	);

	function automatic int unsigned rnd(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic reg_idx_t pick_rd();
		return reg_idx_t'(1 + rnd(30));   // x31 stays the data base
	endfunction

	function automatic reg_idx_t pick_rs();
		return reg_idx_t'(1 + rnd(31));
	endfunction

	function automatic inst_word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic inst_word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
			input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic inst_word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic inst_word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic inst_word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic inst_word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [11:0] aligned_ofs(input logic [1:0] size);
		logic [11:0] ofs;
		ofs = 12'(rnd(256));
		if (size == 2'b01)
			ofs[0] = 1'b0;
		else if (size == 2'b10)
			ofs[1:0] = 2'b00;
		return ofs;
	endfunction

	task automatic put(input inst_word_t w);
		mem[prog_len] = w;
		prog_len++;
	endtask

	task automatic put_alu();
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = 3'(rnd(8));
		f7 = ((f3 == 3'b000 || f3 == 3'b101) && rnd(2) != 0) ? 7'b0100000 : 7'b0000000;
		put(enc_r(f7, pick_rs(), pick_rs(), f3, pick_rd()));
	endtask

	task automatic build_program();
		int kind;
		int skip;
		logic [2:0] f3;
		logic [11:0] ofs;
		reg_idx_t rs;
		for (int i = 0; i < ISS_MEM_WORDS; i++)
			mem[i] = (xlen_t'(i) * 32'h9e3779b1) ^ 32'h0badf00d;
		for (int i = DATA_BASE / 4; i < DATA_BASE / 4 + 64; i++)
			mem[i] = $random(seed);
		prog_len = 0;
		for (int r = 1; r < 31; r++) begin
			put(enc_u(20'(rnd(1 << 20)), reg_idx_t'(r), OPC_LUI));
			put(enc_i(12'(rnd(4096)), reg_idx_t'(r), 3'b000, reg_idx_t'(r), OPC_OP_IMM));
		end
		put(enc_i(DATA_BASE, 5'd0, 3'b000, 5'd31, OPC_OP_IMM));
		while (prog_len < 400) begin
			kind = rnd(16);
			skip = 1 + rnd(2);
			f3 = 3'(rnd(8));
			if (kind < 4) begin
				put_alu();
			end else if (kind < 7) begin
				ofs = 12'(rnd(4096));
				if (f3 == 3'b001)
					ofs[11:5] = 7'b0000000;
				else if (f3 == 3'b101)
					ofs[11:5] = (rnd(2) != 0) ? 7'b0100000 : 7'b0000000;
				put(enc_i(ofs, pick_rs(), f3, pick_rd(), OPC_OP_IMM));
			end else if (kind == 7) begin
				if (rnd(4) == 0)
					put(32'h0000_0000);   // undecodable word retires as nop
				else
					put(enc_u(20'(rnd(1 << 20)), pick_rd(), f3[0] ? OPC_LUI : OPC_AUIPC));
			end else if (kind < 10) begin
				rs = pick_rs();
				f3 = 3'(rnd(6));
				if (f3 > 3'd1)
					f3 = f3 + 3'd2;
				put(enc_b(13'(4 * (skip + 1)), (rnd(4) == 0) ? rs : pick_rs(), rs, f3));
				repeat (skip) put_alu();
			end else if (kind == 10) begin
				put(enc_j(21'(4 * (skip + 1)), pick_rd()));
				repeat (skip) put_alu();
			end else if (kind == 11) begin
				put(enc_u(20'd0, 5'd30, OPC_AUIPC));
				put(enc_i(12'd12, 5'd30, 3'b000, pick_rd(), OPC_JALR));
				put(32'h0000_0000);   // jumped over
			end else if (kind < 14) begin
				rs = pick_rd();
				f3 = 3'(rnd(5));
				if (f3 > 3'd2)
					f3 = f3 + 3'd1;
				put(enc_i(aligned_ofs(f3[1:0]), 5'd31, f3, rs, OPC_LOAD));
				put(enc_s(aligned_ofs(2'b10), rs, 5'd31, 3'b010));   // loaded value goes back out
			end else begin
				f3 = 3'(rnd(3));
				put(enc_s(aligned_ofs(f3[1:0]), pick_rs(), 5'd31, f3));
			end
		end
		put(32'h0000_0013);
		end_pc = xlen_t'(prog_len * 4);
		put(enc_j(21'd0, 5'd0));   // jump to itself
		iss_mem = mem;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string test, input xlen_t exp, input xlen_t act);
		abort_run($sformatf("ERROR %s: expected %h, actual %h", test, exp, act));
	endtask

	task automatic take_read_addr();
		inst_word_t w;
		xlen_t ea;
		ar_count++;
		if (load_pending) begin
			assert (rd_req.addr == load_addr)
				else report_mismatch("load address", load_addr, rd_req.addr);
			load_pending = 1'b0;
		end else begin
			assert (rd_req.addr == iss_pc)
				else report_mismatch("fetch address", iss_pc, rd_req.addr);
			if (iss_pc == end_pc)
				end_hits++;
			w = iss_mem[iss_pc[11:2]];
			ea = iss_x[w[19:15]] + {{20{w[31]}}, w[31:20]};
			if (w[6:0] == OPC_LOAD) begin
				load_pending = 1'b1;
				load_addr = {ea[31:2], 2'b00};
			end
			step_model();
		end
	endtask

	task automatic check_write();
		aw_count++;
		assert (aw_count <= iss_writes)
			else abort_run("write transfer seen with no store left in the program");
		assert (wr_req.addr == iss_waddr)
			else report_mismatch("store address", iss_waddr, wr_req.addr);
		assert (wr_req.strb == iss_wstrb)
			else report_mismatch("store strobe", 32'(iss_wstrb), 32'(wr_req.strb));
		assert (wr_req.data == iss_wdata)
			else report_mismatch("store data", iss_wdata, wr_req.data);
	endtask

	task automatic track_stall();
		logic waiting;
		logic moved;
		waiting = rd_req.valid | r_ready | wr_req.aw_valid | wr_req.w_valid | b_ready;
		moved = (rd_req.valid & ar_ready) | (r_valid & r_ready) |
			(wr_req.aw_valid & aw_ready) | (wr_req.w_valid & w_ready) | (b_valid & b_ready);
		if (waiting && !moved)
			stall++;
		else
			stall = 0;
		if (stall > HS_LIMIT)
			abort_run("a bus handshake stalled past its timeout");
	endtask

	// memory model with random stalls on every ready and response
	always @(posedge clk) begin
		if (!rstn) begin
			ar_ready <= 1'b0;
			aw_ready <= 1'b0;
			w_ready <= 1'b0;
			r_valid <= 1'b0;
			b_valid <= 1'b0;
			rd_pend <= 1'b0;
			aw_seen <= 1'b0;
			w_seen <= 1'b0;
		end else begin
			ar_ready <= rnd(4) != 0;
			aw_ready <= rnd(4) != 0;
			w_ready <= rnd(4) != 0;
			if (rd_req.valid && ar_ready) begin
				rd_addr <= rd_req.addr;
				rd_pend <= 1'b1;
			end
			if (rd_pend && !r_valid && rnd(3) != 0) begin
				r_valid <= 1'b1;
				r_data <= mem[rd_addr[11:2]];
			end
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				rd_pend <= 1'b0;
			end
			if (wr_req.aw_valid && aw_ready)
				aw_seen <= 1'b1;
			if (wr_req.w_valid && w_ready) begin
				w_seen <= 1'b1;
				for (int k = 0; k < 4; k++) begin
					if (wr_req.strb[k])
						mem[wr_req.addr[11:2]][8*k +: 8] <= wr_req.data[8*k +: 8];
				end
			end
			if (aw_seen && w_seen && !b_valid && rnd(3) != 0)
				b_valid <= 1'b1;
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
				aw_seen <= 1'b0;
				w_seen <= 1'b0;
			end
		end
	end

	// transfers land on the next rising edge
	always @(negedge clk) begin
		if (rstn) begin
			if (rd_req.valid && ar_ready)
				take_read_addr();
			if (r_valid && r_ready)
				r_count++;
			if (wr_req.aw_valid && aw_ready)
				check_write();
			if (b_valid && b_ready)
				b_count++;
			track_stall();
		end
	end

	initial begin
		int cyc;
		logic [8:0] idle_outs;
		reset_model();
		build_program();
		repeat (15) @(posedge clk);
		@(negedge clk);
		idle_outs = {rd_req.valid, r_ready, wr_req.aw_valid, wr_req.w_valid, b_ready,
			wr_req.strb};
		assert (idle_outs == '0)
			else report_mismatch("outputs in reset", '0, 32'(idle_outs));
		@(posedge clk);
		rstn <= 1'b1;
		for (cyc = 0; cyc < HS_LIMIT && !rd_req.valid; cyc++)
			@(negedge clk);
		if (!rd_req.valid)
			abort_run("no instruction fetch started after reset");
		assert (rd_req.addr == RESET_PC)
			else report_mismatch("first fetch address", RESET_PC, rd_req.addr);
		for (cyc = 0; cyc < RUN_LIMIT && end_hits < 2; cyc++)
			@(posedge clk);
		if (end_hits < 2)
			abort_run("program never reached its final self jump");
		for (cyc = 0; cyc < HS_LIMIT && r_count < ar_count; cyc++)
			@(posedge clk);
		assert (r_count == ar_count)
			else report_mismatch("read responses", ar_count, r_count);
		assert (aw_count == iss_writes)
			else report_mismatch("write count", iss_writes, aw_count);
		assert (b_count == iss_writes)
			else report_mismatch("write responses", iss_writes, b_count);
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== rv_core.f ====
+incdir+include
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_mem_align.sv
logic/rv_bus_master.sv
logic/rv_core.sv
sim/rv_core_tb.sv
